//--- source/ooo_core_pkg.sv
package ooo_core_pkg;

    // Datapath and register file sizing
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 1 << REG_IDX_W;

    // Reorder buffer sizing, ROB_SIZE must be a power of two
    localparam int ROB_SIZE  = 8;
    localparam int ROB_IDX_W = 3;
    localparam int ROB_CNT_W = ROB_IDX_W + 1;

    localparam int MUL_STAGES = 3;

    // Instruction word fields
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;
    localparam int RD_MSB  = 27;
    localparam int RD_LSB  = 23;
    localparam int RS1_MSB = 22;
    localparam int RS1_LSB = 18;
    localparam int RS2_MSB = 17;
    localparam int RS2_LSB = 13;
    localparam int IMM_MSB = 12;
    localparam int IMM_LSB = 0;
    localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,
        OP_MUL  = 4'd6
    } opcode_e;

    typedef enum logic [1:0] {
        EXC_NONE    = 2'd0,
        EXC_ILLEGAL = 2'd1
    } exc_e;

    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

endpackage

//--- source/exec_done_if.sv
`timescale 1ns/10ps

interface exec_done_if import ooo_core_pkg::*; ();

    // One-cycle completion strobe with the entry it finishes
    logic                 done;
    logic [ROB_IDX_W-1:0] idx;
    logic [XLEN-1:0]      value;
    exc_e                 exc;

    modport unit (
        output done, idx, value, exc
    );

    modport buffer (
        input done, idx, value, exc
    );

endinterface

//--- source/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import ooo_core_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  logic [XLEN-1:0]      instr,
    input  logic [XLEN-1:0]      instr_pc,
    output logic                 instr_ready,
    input  logic                 flush,
    input  logic                 full,
    input  logic [ROB_IDX_W-1:0] alloc_idx,
    output logic                 alloc,
    output logic [REG_IDX_W-1:0] alloc_rd,
    output logic [XLEN-1:0]      alloc_pc,
    output exc_e                 alloc_exc,
    output unit_e                alloc_unit,
    output logic [REG_IDX_W-1:0] rs1,
    output logic [REG_IDX_W-1:0] rs2,
    input  logic                 rs1_hit,
    input  logic                 rs1_pending,
    input  logic [XLEN-1:0]      rs1_fwd,
    input  logic                 rs2_hit,
    input  logic                 rs2_pending,
    input  logic [XLEN-1:0]      rs2_fwd,
    input  logic [XLEN-1:0]      rf_rs1_data,
    input  logic [XLEN-1:0]      rf_rs2_data,
    output logic                 issue_valid,
    output unit_e                issue_unit,
    output opcode_e              issue_op,
    output logic [ROB_IDX_W-1:0] issue_idx,
    output logic [XLEN-1:0]      issue_a,
    output logic [XLEN-1:0]      issue_b
);

    opcode_e          opcode;
    logic             legal;
    logic             uses_rs2;
    logic [IMM_W-1:0] imm;
    logic [XLEN-1:0]  imm_ext;
    logic             operand_wait;
    logic             accept;

    assign opcode   = opcode_e'(instr[OPC_MSB:OPC_LSB]);
    assign alloc_rd = instr[RD_MSB:RD_LSB];
    assign rs1      = instr[RS1_MSB:RS1_LSB];
    assign rs2      = instr[RS2_MSB:RS2_LSB];
    assign imm      = instr[IMM_MSB:IMM_LSB];
    assign imm_ext  = {{(XLEN - IMM_W){imm[IMM_W-1]}}, imm};

    always_comb begin
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MUL: legal = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    assign uses_rs2 = legal && (opcode != OP_ADDI);

    // Hold the word while a needed source is still in flight
    assign operand_wait = legal && (rs1_pending || (uses_rs2 && rs2_pending));
    assign instr_ready  = !full && !operand_wait && !flush;
    assign accept       = instr_valid && instr_ready;

    assign alloc      = accept;
    assign alloc_pc   = instr_pc;
    assign alloc_exc  = legal ? EXC_NONE : EXC_ILLEGAL;
    assign alloc_unit = (opcode == OP_MUL) ? UNIT_MUL : UNIT_ALU;

    // Undefined words take an entry but go to no unit
    assign issue_valid = accept && legal;
    assign issue_unit  = alloc_unit;
    assign issue_op    = opcode;
    assign issue_idx   = alloc_idx;
    assign issue_a     = rs1_hit ? rs1_fwd : rf_rs1_data;
    assign issue_b     = !uses_rs2 ? imm_ext : (rs2_hit ? rs2_fwd : rf_rs2_data);

    // Buffer full must always hold allocation back
    a_no_alloc_full: assert property (@(posedge clk) disable iff (reset) alloc |-> !full)
        else $error("alloc while reorder buffer full");

endmodule

//--- source/alu_unit.sv
`timescale 1ns/10ps

module alu_unit import ooo_core_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  opcode_e              issue_op,
    input  logic [ROB_IDX_W-1:0] issue_idx,
    input  logic [XLEN-1:0]      issue_a,
    input  logic [XLEN-1:0]      issue_b,
    exec_done_if.unit            done
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (issue_op)
            OP_ADD:  result = issue_a + issue_b;
            OP_SUB:  result = issue_a - issue_b;
            OP_AND:  result = issue_a & issue_b;
            OP_OR:   result = issue_a | issue_b;
            OP_XOR:  result = issue_a ^ issue_b;
            // Immediate already sign extended into operand b
            OP_ADDI: result = issue_a + issue_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done.done <= 1'b0;
        end else begin
            done.done <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            done.idx   <= issue_idx;
            done.value <= result;
        end
    end

    assign done.exc = EXC_NONE;

endmodule

//--- source/mul_unit.sv
`timescale 1ns/10ps

module mul_unit import ooo_core_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 issue_valid,
    input  logic [ROB_IDX_W-1:0] issue_idx,
    input  logic [XLEN-1:0]      issue_a,
    input  logic [XLEN-1:0]      issue_b,
    exec_done_if.unit            done
);

    logic [MUL_STAGES-1:0] valid;
    logic [ROB_IDX_W-1:0]  idx [MUL_STAGES];

    // Stage 0 operands
    logic [XLEN-1:0]   a_q;
    logic [XLEN-1:0]   b_q;
    // Stage 1 partial products, only the low half of the cross terms matters
    logic [XLEN-1:0]   p_low;
    logic [XLEN/2-1:0] p_cross;
    // Stage 2 low word of the product
    logic [XLEN-1:0]   product;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= '0;
        end else begin
            valid <= {valid[MUL_STAGES-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        idx[0] <= issue_idx;
        for (int s = 1; s < MUL_STAGES; s++) begin
            idx[s] <= idx[s-1];
        end

        a_q <= issue_a;
        b_q <= issue_b;

        p_low   <= a_q[XLEN/2-1:0] * b_q[XLEN/2-1:0];
        p_cross <= a_q[XLEN/2-1:0] * b_q[XLEN-1:XLEN/2]
                 + a_q[XLEN-1:XLEN/2] * b_q[XLEN/2-1:0];

        product <= p_low + {p_cross, {(XLEN/2){1'b0}}};
    end

    assign done.done  = valid[MUL_STAGES-1];
    assign done.idx   = idx[MUL_STAGES-1];
    assign done.value = product;
    assign done.exc   = EXC_NONE;

endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer import ooo_core_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 commit_stall,
    input  logic                 alloc,
    input  logic [REG_IDX_W-1:0] alloc_rd,
    input  logic [XLEN-1:0]      alloc_pc,
    input  exc_e                 alloc_exc,
    input  unit_e                alloc_unit,
    output logic [ROB_IDX_W-1:0] alloc_idx,
    output logic                 full,
    exec_done_if.buffer          alu_done,
    exec_done_if.buffer          mul_done,
    input  logic [REG_IDX_W-1:0] rs1,
    input  logic [REG_IDX_W-1:0] rs2,
    output logic                 rs1_hit,
    output logic                 rs1_pending,
    output logic [XLEN-1:0]      rs1_fwd,
    output logic                 rs2_hit,
    output logic                 rs2_pending,
    output logic [XLEN-1:0]      rs2_fwd,
    output logic                 retire,
    output logic [REG_IDX_W-1:0] retire_rd,
    output logic [XLEN-1:0]      retire_value,
    output logic                 commit_valid,
    output logic [XLEN-1:0]      commit_pc,
    output logic [REG_IDX_W-1:0] commit_rd,
    output logic [XLEN-1:0]      commit_value,
    output exc_e                 commit_exc,
    output logic                 flush
);

    logic                 valid      [ROB_SIZE];
    logic                 complete   [ROB_SIZE];
    logic [XLEN-1:0]      pc         [ROB_SIZE];
    logic [REG_IDX_W-1:0] rd         [ROB_SIZE];
    logic [XLEN-1:0]      value      [ROB_SIZE];
    exc_e                 exc        [ROB_SIZE];
    unit_e                entry_unit [ROB_SIZE];

    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] tail;
    logic [ROB_CNT_W-1:0] count;
    logic                 take_exc;

    assign alloc_idx = tail;
    assign full      = (count == ROB_CNT_W'(ROB_SIZE));

    // Head retires once it is complete
    assign commit_valid = valid[head] && complete[head] && !commit_stall;
    assign commit_pc    = pc[head];
    assign commit_rd    = rd[head];
    assign commit_value = value[head];
    assign commit_exc   = exc[head];

    assign take_exc     = commit_valid && (exc[head] != EXC_NONE);
    assign retire       = commit_valid && !take_exc;
    assign retire_rd    = rd[head];
    assign retire_value = value[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            flush <= 1'b0;
            for (int i = 0; i < ROB_SIZE; i++) begin
                valid[i]    <= 1'b0;
                complete[i] <= 1'b0;
            end
        end else begin
            flush <= take_exc;
            if (take_exc) begin
                // Excepting head drops every younger entry too
                head  <= '0;
                tail  <= '0;
                count <= '0;
                for (int i = 0; i < ROB_SIZE; i++) begin
                    valid[i]    <= 1'b0;
                    complete[i] <= 1'b0;
                end
            end else begin
                if (alu_done.done && valid[alu_done.idx]) begin
                    complete[alu_done.idx] <= 1'b1;
                end
                if (mul_done.done && valid[mul_done.idx]) begin
                    complete[mul_done.idx] <= 1'b1;
                end
                if (commit_valid) begin
                    valid[head]    <= 1'b0;
                    complete[head] <= 1'b0;
                    head           <= head + ROB_IDX_W'(1);
                end
                if (alloc) begin
                    valid[tail]    <= 1'b1;
                    complete[tail] <= (alloc_exc != EXC_NONE);
                    tail           <= tail + ROB_IDX_W'(1);
                end
                case ({alloc, commit_valid})
                    2'b10:   count <= count + ROB_CNT_W'(1);
                    2'b01:   count <= count - ROB_CNT_W'(1);
                    default: count <= count;
                endcase
            end
        end
    end

    // Entry payload, allocation last so it wins over a stale report
    always_ff @(posedge clk) begin
        if (alu_done.done) begin
            value[alu_done.idx] <= alu_done.value;
            exc[alu_done.idx]   <= alu_done.exc;
        end
        if (mul_done.done) begin
            value[mul_done.idx] <= mul_done.value;
            exc[mul_done.idx]   <= mul_done.exc;
        end
        if (alloc) begin
            pc[tail]         <= alloc_pc;
            rd[tail]         <= alloc_rd;
            value[tail]      <= '0;
            exc[tail]        <= alloc_exc;
            entry_unit[tail] <= alloc_unit;
        end
    end

    // Operand lookup, walking oldest to newest so the newest match wins
    always_comb begin
        logic [ROB_IDX_W-1:0] slot;

        rs1_hit     = 1'b0;
        rs1_pending = 1'b0;
        rs1_fwd     = '0;
        rs2_hit     = 1'b0;
        rs2_pending = 1'b0;
        rs2_fwd     = '0;
        for (int i = 0; i < ROB_SIZE; i++) begin
            slot = head + ROB_IDX_W'(i);
            if (valid[slot] && (rs1 != '0) && (rd[slot] == rs1)) begin
                rs1_hit     = complete[slot];
                rs1_pending = !complete[slot];
                rs1_fwd     = value[slot];
            end
            if (valid[slot] && (rs2 != '0) && (rd[slot] == rs2)) begin
                rs2_hit     = complete[slot];
                rs2_pending = !complete[slot];
                rs2_fwd     = value[slot];
            end
        end
    end

    // Reports land on a live entry of the right unit, except in the flush cycle
    a_alu_target: assert property (@(posedge clk) disable iff (reset)
        alu_done.done |-> flush || (valid[alu_done.idx] && entry_unit[alu_done.idx] == UNIT_ALU))
        else $error("ALU completion to dead entry %0d", alu_done.idx);

    a_mul_target: assert property (@(posedge clk) disable iff (reset)
        mul_done.done |-> flush || (valid[mul_done.idx] && entry_unit[mul_done.idx] == UNIT_MUL))
        else $error("MUL completion to dead entry %0d", mul_done.idx);

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= ROB_CNT_W'(ROB_SIZE))
        else $error("entry count %0d over capacity", count);

endmodule

//--- source/arch_regfile.sv
`timescale 1ns/10ps

module arch_regfile import ooo_core_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 retire,
    input  logic [REG_IDX_W-1:0] retire_rd,
    input  logic [XLEN-1:0]      retire_value,
    input  logic [REG_IDX_W-1:0] rs1,
    input  logic [REG_IDX_W-1:0] rs2,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // Register zero is never written and stays at its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire && (retire_rd != '0)) begin
            regs[retire_rd] <= retire_value;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- source/ooo_core.sv
`timescale 1ns/10ps

module ooo_core import ooo_core_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  logic [XLEN-1:0]      instr,
    input  logic [XLEN-1:0]      instr_pc,
    input  logic                 commit_stall,
    output logic                 instr_ready,
    output logic                 commit_valid,
    output logic [XLEN-1:0]      commit_pc,
    output logic [REG_IDX_W-1:0] commit_rd,
    output logic [XLEN-1:0]      commit_value,
    output exc_e                 commit_exc,
    output logic                 flush
);

    // Allocation and lookup between decoder and buffer
    logic                 full;
    logic [ROB_IDX_W-1:0] alloc_idx;
    logic                 alloc;
    logic [REG_IDX_W-1:0] alloc_rd;
    logic [XLEN-1:0]      alloc_pc;
    exc_e                 alloc_exc;
    unit_e                alloc_unit;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic                 rs1_hit;
    logic                 rs1_pending;
    logic [XLEN-1:0]      rs1_fwd;
    logic                 rs2_hit;
    logic                 rs2_pending;
    logic [XLEN-1:0]      rs2_fwd;
    logic [XLEN-1:0]      rf_rs1_data;
    logic [XLEN-1:0]      rf_rs2_data;

    // Issue toward the execution units
    logic                 issue_valid;
    unit_e                issue_unit;
    opcode_e              issue_op;
    logic [ROB_IDX_W-1:0] issue_idx;
    logic [XLEN-1:0]      issue_a;
    logic [XLEN-1:0]      issue_b;
    logic                 alu_issue;
    logic                 mul_issue;

    logic                 retire;
    logic [REG_IDX_W-1:0] retire_rd;
    logic [XLEN-1:0]      retire_value;

    exec_done_if alu_done ();
    exec_done_if mul_done ();

    assign alu_issue = issue_valid && (issue_unit == UNIT_ALU);
    assign mul_issue = issue_valid && (issue_unit == UNIT_MUL);

    instr_decoder u_instr_decoder (.*);

    alu_unit u_alu_unit (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (alu_issue),
        .issue_op    (issue_op),
        .issue_idx   (issue_idx),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .done        (alu_done)
    );

    mul_unit u_mul_unit (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (mul_issue),
        .issue_idx   (issue_idx),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .done        (mul_done)
    );

    reorder_buffer u_reorder_buffer (
        .alu_done (alu_done),
        .mul_done (mul_done),
        .*
    );

    arch_regfile u_arch_regfile (
        .clk          (clk),
        .reset        (reset),
        .retire       (retire),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_data     (rf_rs1_data),
        .rs2_data     (rf_rs2_data)
    );

endmodule

//--- testbench/ooo_core_tb.sv
`timescale 1ns/10ps

module ooo_core_tb import ooo_core_pkg::*; ();

    localparam int TIMEOUT   = 100;
    localparam int EXP_DEPTH = 256;

    logic                 clk;
    logic                 reset;
    logic                 instr_valid;
    logic [XLEN-1:0]      instr;
    logic [XLEN-1:0]      instr_pc;
    logic                 commit_stall;
    logic                 instr_ready;
    logic                 commit_valid;
    logic [XLEN-1:0]      commit_pc;
    logic [REG_IDX_W-1:0] commit_rd;
    logic [XLEN-1:0]      commit_value;
    exc_e                 commit_exc;
    logic                 flush;

    // Reference model, speculative at acceptance and architectural at commit
    logic [XLEN-1:0]      spec_regs [NUM_REGS];
    logic [XLEN-1:0]      arch_regs [NUM_REGS];
    logic [XLEN-1:0]      exp_pc    [EXP_DEPTH];
    logic [REG_IDX_W-1:0] exp_rd    [EXP_DEPTH];
    logic [XLEN-1:0]      exp_value [EXP_DEPTH];
    exc_e                 exp_exc   [EXP_DEPTH];
    logic [7:0]           acc_seq;
    logic [7:0]           ret_seq;
    logic [XLEN-1:0]      next_pc;
    int                   flush_count;
    int                   flushes_seen;
    int                   commits;
    int                   errors;
    int                   last_wait;
    int                   tests_run;
    int                   tests_failed;

    ooo_core u_ooo_core (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Retire side of the model follows the commits of the DUT
    always @(posedge clk) begin
        if (reset) begin
            ret_seq     <= '0;
            flush_count <= 0;
            commits     = 0;
            for (int r = 0; r < NUM_REGS; r++) begin
                arch_regs[r] = '0;
            end
        end else if (commit_valid) begin
            commits++;
            if (exp_exc[ret_seq] != EXC_NONE) begin
                // Everything younger than the exception is dropped
                ret_seq     <= acc_seq;
                flush_count <= flush_count + 1;
            end else begin
                if (exp_rd[ret_seq] != '0) begin
                    arch_regs[exp_rd[ret_seq]] = exp_value[ret_seq];
                end
                ret_seq <= ret_seq + 8'd1;
            end
        end
    end

    task automatic note_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] expected);
        errors++;
        $display("error %s got %h expected %h at %0t", name, got, expected, $time);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    a_commit_expected: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> ret_seq != acc_seq)
        else note_failure("commit with no instruction outstanding");

    a_commit_pc: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> commit_pc == exp_pc[ret_seq])
        else note_mismatch("commit_pc", $sampled(commit_pc), exp_pc[$sampled(ret_seq)]);

    a_commit_rd: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> commit_rd == exp_rd[ret_seq])
        else note_mismatch("commit_rd", 32'($sampled(commit_rd)),
                           32'(exp_rd[$sampled(ret_seq)]));

    a_commit_exc: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> commit_exc == exp_exc[ret_seq])
        else note_mismatch("commit_exc", 32'($sampled(commit_exc)),
                           32'(exp_exc[$sampled(ret_seq)]));

    a_commit_value: assert property (@(posedge clk) disable iff (reset)
        commit_valid && exp_exc[ret_seq] == EXC_NONE |-> commit_value == exp_value[ret_seq])
        else note_mismatch("commit_value", $sampled(commit_value),
                           exp_value[$sampled(ret_seq)]);

    a_flush_follows: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_exc != EXC_NONE |=> flush)
        else note_failure("flush did not follow an exception commit");

    a_flush_cause: assert property (@(posedge clk) disable iff (reset)
        flush |-> $past(commit_valid && commit_exc != EXC_NONE))
        else note_failure("flush without an exception commit before it");

    function automatic logic [XLEN-1:0] encode(input logic [3:0] op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [12:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [XLEN-1:0] random_instr();
        logic [3:0] op;

        op = 4'($urandom_range(6));
        return encode(op, 5'($urandom_range(7, 1)), 5'($urandom_range(7)),
                      5'($urandom_range(7)), 13'($urandom));
    endfunction

    // Executes one accepted word in program order
    task automatic model_accept(input logic [XLEN-1:0] word);
        logic [3:0]           op;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      a;
        logic [XLEN-1:0]      b;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      result;
        exc_e                 exc;

        if (flushes_seen != flush_count) begin
            spec_regs    = arch_regs;
            flushes_seen = flush_count;
        end
        op  = word[31:28];
        rd  = word[27:23];
        a   = spec_regs[word[22:18]];
        b   = spec_regs[word[17:13]];
        imm = {{19{word[12]}}, word[12:0]};
        exc = EXC_NONE;
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_ADDI: result = a + imm;
            OP_MUL:  result = a * b;
            default: begin
                result = '0;
                exc    = EXC_ILLEGAL;
            end
        endcase
        if (exc == EXC_NONE && rd != '0) begin
            spec_regs[rd] = result;
        end
        exp_pc[acc_seq]    = next_pc;
        exp_rd[acc_seq]    = rd;
        exp_value[acc_seq] = result;
        exp_exc[acc_seq]   = exc;
        acc_seq            = acc_seq + 8'd1;
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Called on a falling edge, returns on a falling edge with instr_valid low
    task automatic try_issue(input logic [XLEN-1:0] word, input int limit, output logic accepted);
        int waited;

        instr_valid = 1'b1;
        instr       = word;
        instr_pc    = next_pc;
        waited      = 0;
        #1;
        while (!instr_ready && waited < limit) begin
            @(negedge clk);
            #1;
            waited++;
        end
        accepted  = instr_ready;
        last_wait = waited;
        if (accepted) begin
            model_accept(word);
            next_pc = next_pc + 32'd4;
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic issue_instr(input logic [XLEN-1:0] word);
        logic ok;

        try_issue(word, TIMEOUT, ok);
        if (!ok) begin
            fail_timeout("instruction acceptance");
        end
    endtask

    task automatic wait_drained();
        int waited;

        waited = 0;
        while (ret_seq != acc_seq && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ret_seq != acc_seq) begin
            fail_timeout("the reorder buffer to drain");
        end
    endtask

    task automatic wait_flush(input int flushes_before);
        int waited;

        waited = 0;
        while (flush_count == flushes_before && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (flush_count == flushes_before) begin
            fail_timeout("the exception flush");
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: pass, %0d commits", tests_run, name, commits);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    initial begin
        int   e0;
        int   accepted_n;
        int   flushes_before;
        int   commits_before;
        logic ok;

        void'($urandom(12));
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        instr_pc     = '0;
        commit_stall = 1'b0;
        next_pc      = 32'h0000_1000;
        acc_seq      = '0;
        flushes_seen = 0;
        errors       = 0;
        last_wait    = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            spec_regs[r] = '0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;

        e0 = errors;
        #1;
        assert (instr_ready && !commit_valid && !flush)
            else note_failure("outputs not idle after reset");
        @(negedge clk);
        end_test("reset state", e0);

        // Seed registers, then a multiply overtaken by independent ALU work
        e0 = errors;
        for (int r = 1; r < 8; r++) begin
            issue_instr(encode(OP_ADDI, 5'(r), 5'd0, 5'd0, 13'($urandom)));
        end
        issue_instr(encode(OP_MUL, 5'd1, 5'd2, 5'd3, 13'd0));
        issue_instr(encode(OP_ADD, 5'd4, 5'd5, 5'd6, 13'd0));
        issue_instr(encode(OP_XOR, 5'd5, 5'd6, 5'd7, 13'd0));
        for (int n = 0; n < 40; n++) begin
            issue_instr(random_instr());
        end
        wait_drained();
        end_test("commit order", e0);

        e0 = errors;
        issue_instr(encode(OP_ADDI, 5'd1, 5'd1, 5'd0, 13'd3));
        issue_instr(encode(OP_ADD, 5'd2, 5'd1, 5'd1, 13'd0));
        issue_instr(encode(OP_MUL, 5'd3, 5'd2, 5'd2, 13'd0));
        issue_instr(encode(OP_SUB, 5'd4, 5'd3, 5'd1, 13'd0));
        assert (last_wait >= 2)
            else note_failure("instr_ready stayed high for a consumer of a pending multiply");
        // Producer complete but held unretired
        commit_stall = 1'b1;
        issue_instr(encode(OP_ADDI, 5'd5, 5'd4, 5'd0, 13'h01f0));
        repeat (3) @(negedge clk);
        issue_instr(encode(OP_ADD, 5'd6, 5'd5, 5'd4, 13'd0));
        assert (last_wait == 0)
            else note_failure("completed result was not forwarded without a wait");
        commit_stall = 1'b0;
        issue_instr(encode(OP_MUL, 5'd7, 5'd6, 5'd5, 13'd0));
        issue_instr(encode(OP_MUL, 5'd7, 5'd7, 5'd7, 13'd0));
        issue_instr(encode(OP_ADD, 5'd1, 5'd7, 5'd6, 13'd0));
        wait_drained();
        end_test("dependent chains", e0);

        e0 = errors;
        issue_instr(encode(OP_ADDI, 5'd0, 5'd1, 5'd0, 13'd55));
        issue_instr(encode(OP_ADD, 5'd2, 5'd0, 5'd0, 13'd0));
        issue_instr(encode(OP_ADDI, 5'd3, 5'd0, 5'd0, 13'h1abc));
        issue_instr(encode(OP_OR, 5'd4, 5'd0, 5'd1, 13'd0));
        wait_drained();
        end_test("register zero", e0);

        // Independent words, so only a full buffer can refuse them
        e0 = errors;
        commit_stall   = 1'b1;
        commits_before = commits;
        accepted_n     = 0;
        ok             = 1'b1;
        while (ok && accepted_n <= ROB_SIZE) begin
            try_issue(encode(OP_ADDI, 5'(accepted_n % 7 + 1), 5'd0, 5'd0, 13'($urandom)), 4, ok);
            if (ok) begin
                accepted_n++;
            end
        end
        assert (!ok && accepted_n <= ROB_SIZE)
            else note_failure("instr_ready stayed high with commit_stall held");
        assert (commits == commits_before)
            else note_failure("instructions retired while commit_stall was held");
        commit_stall = 1'b0;
        wait_drained();
        end_test("back-pressure", e0);

        e0 = errors;
        issue_instr(encode(OP_ADDI, 5'd2, 5'd0, 5'd0, 13'd77));
        issue_instr(encode(OP_ADDI, 5'd1, 5'd1, 5'd0, 13'd5));
        flushes_before = flush_count;
        issue_instr({4'hf, 5'd2, 5'd1, 5'd1, 13'd0});
        issue_instr(encode(OP_ADD, 5'd3, 5'd1, 5'd1, 13'd0));
        wait_flush(flushes_before);
        // r2 must still hold its value from before the undefined word
        issue_instr(encode(OP_ADD, 5'd4, 5'd2, 5'd2, 13'd0));
        issue_instr(encode(OP_MUL, 5'd5, 5'd4, 5'd1, 13'd0));
        issue_instr(encode(OP_SUB, 5'd6, 5'd5, 5'd3, 13'd0));
        wait_drained();
        end_test("exception and flush", e0);

        $display("%0d tests, %0d failed, %0d commits, %0d errors",
                 tests_run, tests_failed, commits, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- ooo_core.f
source/ooo_core_pkg.sv
source/exec_done_if.sv
source/instr_decoder.sv
source/alu_unit.sv
source/mul_unit.sv
source/reorder_buffer.sv
source/arch_regfile.sv
source/ooo_core.sv
testbench/ooo_core_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP      := ooo_core_tb
FILELIST := ooo_core.f
LOG      := sim.log
FAIL_MSG := CHECKS FAILED
PASS_MSG := ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
